// File: source/cpu_pkg.sv
// Shared definitions for the five-stage pipelined processor.
// Holds the word and register types, the opcode and ALU encodings, the
// instruction field positions and small field decoders. Every stage imports
// this package with a wildcard import in its module header.
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;

    typedef enum logic [4:0] {
        op_alu  = 5'd0,
        op_j    = 5'd1,
        op_bne  = 5'd2,
        op_jal  = 5'd3,
        op_jr   = 5'd4,
        op_addi = 5'd5,
        op_blt  = 5'd6,
        op_sw   = 5'd7,
        op_lw   = 5'd8
    } opcode_t;

    typedef enum logic [4:0] {
        alu_add = 5'd0,
        alu_sub = 5'd1,
        alu_and = 5'd2,
        alu_or  = 5'd3,
        alu_sll = 5'd4,
        alu_sra = 5'd5
    } alu_op_t;

    // jal writes its return address here
    localparam reg_addr_t link_reg = 5'd31;

    // add r0, r0, r0
    localparam word_t nop = '0;

    localparam int opcode_msb = 31;
    localparam int opcode_lsb = 27;
    localparam int rd_msb = 26;
    localparam int rd_lsb = 22;
    localparam int rs_msb = 21;
    localparam int rs_lsb = 17;
    localparam int rt_msb = 16;
    localparam int rt_lsb = 12;
    localparam int shamt_msb = 11;
    localparam int shamt_lsb = 7;
    localparam int alu_op_msb = 6;
    localparam int alu_op_lsb = 2;
    localparam int imm_width = 17;
    localparam int target_width = 27;

    function automatic opcode_t insn_opcode(word_t insn);
        return opcode_t'(insn[opcode_msb:opcode_lsb]);
    endfunction

    function automatic reg_addr_t insn_rd(word_t insn);
        return insn[rd_msb:rd_lsb];
    endfunction

    function automatic reg_addr_t insn_rs(word_t insn);
        return insn[rs_msb:rs_lsb];
    endfunction

    function automatic reg_addr_t insn_rt(word_t insn);
        return insn[rt_msb:rt_lsb];
    endfunction

    function automatic logic [4:0] insn_shamt(word_t insn);
        return insn[shamt_msb:shamt_lsb];
    endfunction

    function automatic alu_op_t insn_alu_op(word_t insn);
        return alu_op_t'(insn[alu_op_msb:alu_op_lsb]);
    endfunction

    function automatic word_t insn_imm(word_t insn);
        return {{(32 - imm_width){insn[imm_width-1]}}, insn[imm_width-1:0]};
    endfunction

    function automatic word_t insn_target(word_t insn);
        return {{(32 - target_width){insn[target_width-1]}}, insn[target_width-1:0]};
    endfunction

    // Stores, compares and jr read rd through register port B
    function automatic reg_addr_t port_b_reg(word_t insn);
        if (insn_opcode(insn) inside {op_sw, op_bne, op_blt, op_jr}) begin
            return insn_rd(insn);
        end
        return insn_rt(insn);
    endfunction

    function automatic logic writes_reg(word_t insn);
        return insn_opcode(insn) inside {op_alu, op_addi, op_lw, op_jal};
    endfunction

    function automatic reg_addr_t dest_reg(word_t insn);
        return (insn_opcode(insn) == op_jal) ? link_reg : insn_rd(insn);
    endfunction

endpackage

// File: source/alu.sv
`timescale 1ns/1ns
// Integer ALU used by the execute stage.
// Computes add, sub, and, or and the two shifts by shamt. The flags compare
// the raw operands and drive branch resolution.
module alu
    import cpu_pkg::*;
(
    input  word_t      a,
    input  word_t      b,
    input  alu_op_t    op,
    input  logic [4:0] shamt,
    output word_t      result,
    output logic       not_equal,
    output logic       less_than
);

    always_comb begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_sll: result = a << shamt;
            alu_sra: result = word_t'($signed(a) >>> shamt);
            // Unused encodings give zero
            default: result = '0;
        endcase
    end

    assign not_equal = (a != b);
    assign less_than = ($signed(a) < $signed(b));

endmodule

// File: source/register_file.sv
`timescale 1ns/1ns
// General purpose register file with two read ports and one write port.
// Register 0 always reads as zero. A write in the same cycle as a read of
// the same register is passed straight through to the read port.
module register_file
    import cpu_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  reg_addr_t wb_addr,
    input  logic      wb_en,
    input  word_t     wb_data,
    output word_t     rs_data,
    output word_t     rt_data
);

    word_t regs [32];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;
        end
    end

    assign rs_data = (rs_addr == '0)                 ? '0 :
                     (wb_en && wb_addr == rs_addr)   ? wb_data : regs[rs_addr];
    assign rt_data = (rt_addr == '0)                 ? '0 :
                     (wb_en && wb_addr == rt_addr)   ? wb_data : regs[rt_addr];

endmodule

// File: source/fetch_stage.sv
`timescale 1ns/1ns
// Fetch stage of the pipeline.
// Keeps the program counter, which addresses the instruction memory directly,
// and the fetch/decode register. A redirect from execute loads the target and
// squashes the word being fetched; a load-use stall freezes both registers.
module fetch_stage
    import cpu_pkg::*;
#(
    parameter word_t reset_pc = '0
) (
    input  logic  clock,
    input  logic  reset,
    input  logic  stall,
    input  logic  redirect,
    input  word_t redirect_pc,
    input  word_t q_imem,
    output word_t pc,
    output word_t fd_insn,
    output word_t fd_pc_next
);

    word_t pc_plus_one;

    assign pc_plus_one = pc + 32'd1;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc_plus_one;
        end
    end

    // Redirect wins over stall, the fetched word is on the wrong path
    always_ff @(posedge clock) begin
        if (reset) begin
            fd_insn <= nop;
        end else if (redirect) begin
            fd_insn <= nop;
        end else if (!stall) begin
            fd_insn <= q_imem;
        end
    end

    // PC+1 travels along for branch offsets and the jal link value
    always_ff @(posedge clock) begin
        if (!stall) begin
            fd_pc_next <= pc_plus_one;
        end
    end

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ns
// Decode stage of the pipeline.
// Picks the register file read addresses, detects the load-use hazard against
// the instruction in execute and fills the decode/execute register. A stall
// or a redirect sends a nop bubble down instead of the decoded instruction.
module decode_stage
    import cpu_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  word_t     fd_insn,
    input  word_t     fd_pc_next,
    input  logic      redirect,
    input  word_t     rs_data,
    input  word_t     rt_data,
    output reg_addr_t rs_addr,
    output reg_addr_t rt_addr,
    output logic      stall,
    output word_t     dx_insn,
    output word_t     dx_pc_next,
    output word_t     dx_a,
    output word_t     dx_b
);

    word_t     insn;
    opcode_t   op;
    reg_addr_t load_rd;
    logic      load_in_execute;
    logic      uses_a;
    logic      uses_b;

    // Younger than a taken branch in execute
    assign insn = redirect ? nop : fd_insn;
    assign op = insn_opcode(insn);

    assign rs_addr = insn_rs(insn);
    assign rt_addr = port_b_reg(insn);

    // Sources the instruction really reads. The sw data source is left out
    // because memory_writeback forwards it from the load
    always_comb begin
        uses_a = 1'b0;
        uses_b = 1'b0;
        case (op)
            op_alu: begin
                uses_a = 1'b1;
                uses_b = !(insn_alu_op(insn) inside {alu_sll, alu_sra});
            end
            op_addi, op_lw, op_sw: begin
                uses_a = 1'b1;
            end
            op_bne, op_blt: begin
                uses_a = 1'b1;
                uses_b = 1'b1;
            end
            op_jr: begin
                uses_b = 1'b1;
            end
            default: ;
        endcase
    end

    assign load_rd = insn_rd(dx_insn);
    assign load_in_execute = (insn_opcode(dx_insn) == op_lw) && (load_rd != '0);

    assign stall = load_in_execute &&
                   ((uses_a && rs_addr == load_rd) || (uses_b && rt_addr == load_rd));

    always_ff @(posedge clock) begin
        if (reset) begin
            dx_insn <= nop;
        end else if (stall) begin
            dx_insn <= nop;
        end else begin
            dx_insn <= insn;
        end
    end

    always_ff @(posedge clock) begin
        dx_pc_next <= fd_pc_next;
        dx_a <= rs_data;
        dx_b <= rt_data;
    end

endmodule

// File: source/execute_stage.sv
`timescale 1ns/1ns
// Execute stage of the pipeline.
// Forwards operands from the memory and writeback stages, runs the ALU,
// resolves branches and jumps and fills the execute/memory register.
// A taken branch or jump raises redirect with the target for fetch.
module execute_stage
    import cpu_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  word_t     dx_insn,
    input  word_t     dx_pc_next,
    input  word_t     dx_a,
    input  word_t     dx_b,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    output logic      redirect,
    output word_t     redirect_pc,
    output word_t     xm_insn,
    output word_t     xm_result,
    output word_t     xm_store
);

    opcode_t   op;
    reg_addr_t a_addr;
    reg_addr_t b_addr;
    reg_addr_t xm_dest;
    logic      xm_forwardable;
    logic      uses_imm;
    word_t     fwd_a;
    word_t     fwd_b;
    word_t     imm;
    word_t     alu_b;
    word_t     alu_result;
    alu_op_t   alu_op;
    logic      not_equal;
    logic      less_than;

    // Memory stage first since it holds the younger value
    function automatic word_t bypass(reg_addr_t addr, word_t reg_value);
        word_t value;
        value = reg_value;
        if (addr != '0) begin
            if (xm_forwardable && xm_dest == addr) begin
                value = xm_result;
            end else if (wb_en && wb_addr == addr) begin
                value = wb_data;
            end
        end
        return value;
    endfunction

    assign op = insn_opcode(dx_insn);
    assign a_addr = insn_rs(dx_insn);
    assign b_addr = port_b_reg(dx_insn);

    // A load in memory only holds its address, its data comes from writeback
    assign xm_dest = dest_reg(xm_insn);
    assign xm_forwardable = writes_reg(xm_insn) && (insn_opcode(xm_insn) != op_lw);

    always_comb begin
        fwd_a = bypass(a_addr, dx_a);
        fwd_b = bypass(b_addr, dx_b);
    end

    assign imm = insn_imm(dx_insn);
    assign uses_imm = op inside {op_addi, op_lw, op_sw};
    assign alu_b = uses_imm ? imm : fwd_b;
    assign alu_op = uses_imm ? alu_add : insn_alu_op(dx_insn);

    alu i_alu (
        .a         (fwd_a),
        .b         (alu_b),
        .op        (alu_op),
        .shamt     (insn_shamt(dx_insn)),
        .result    (alu_result),
        .not_equal (not_equal),
        .less_than (less_than)
    );

    // Port A holds rs and port B holds rd, so blt takes rd < rs
    always_comb begin
        redirect = 1'b0;
        redirect_pc = dx_pc_next + imm;
        case (op)
            op_bne: begin
                redirect = not_equal;
            end
            op_blt: begin
                redirect = not_equal && !less_than;
            end
            op_j, op_jal: begin
                redirect = 1'b1;
                redirect_pc = insn_target(dx_insn);
            end
            op_jr: begin
                redirect = 1'b1;
                redirect_pc = fwd_b;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            xm_insn <= nop;
        end else begin
            xm_insn <= dx_insn;
        end
    end

    // jal carries its return address as the result
    always_ff @(posedge clock) begin
        xm_result <= (op == op_jal) ? dx_pc_next : alu_result;
        xm_store <= fwd_b;
    end

endmodule

// File: source/memory_writeback.sv
`timescale 1ns/1ns
// Memory and writeback stages of the pipeline.
// Drives the data memory from the execute/memory register, forwarding the
// writeback value into store data, then registers the result and load data
// and selects the register file write.
module memory_writeback
    import cpu_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  word_t     xm_insn,
    input  word_t     xm_result,
    input  word_t     xm_store,
    input  word_t     q_dmem,
    output word_t     address_dmem,
    output word_t     data,
    output logic      wren,
    output logic      wb_en,
    output reg_addr_t wb_addr,
    output word_t     wb_data,
    output word_t     mw_insn
);

    opcode_t   mw_op;
    reg_addr_t store_reg;
    word_t     mw_result;
    word_t     mw_load;

    assign address_dmem = xm_result;
    assign wren = (insn_opcode(xm_insn) == op_sw);

    // Covers a load followed directly by a store of the loaded register
    assign store_reg = insn_rd(xm_insn);
    assign data = (wb_en && wb_addr == store_reg) ? wb_data : xm_store;

    always_ff @(posedge clock) begin
        if (reset) begin
            mw_insn <= nop;
        end else begin
            mw_insn <= xm_insn;
        end
    end

    always_ff @(posedge clock) begin
        mw_result <= xm_result;
        mw_load <= q_dmem;
    end

    assign mw_op = insn_opcode(mw_insn);
    assign wb_addr = dest_reg(mw_insn);

    // Writes to r0 never count, so a nop raises no write enable
    assign wb_en = writes_reg(mw_insn) && (wb_addr != '0);
    assign wb_data = (mw_op == op_lw) ? mw_load : mw_result;

endmodule

// File: source/processor.sv
`timescale 1ns/1ns
// Top level of the five-stage pipelined processor.
// Connects fetch, decode, the register file, execute and memory/writeback.
// Only the instruction and data memory ports leave the design; both memories
// answer combinationally in the same cycle. reset_pc sets the first fetch.
module processor
    import cpu_pkg::*;
#(
    parameter word_t reset_pc = '0
) (
    input  logic  clock,
    input  logic  reset,
    output word_t address_imem,
    input  word_t q_imem,
    output word_t address_dmem,
    output word_t data,
    output logic  wren,
    input  word_t q_dmem
);

    // Hazard control
    logic      stall;
    logic      redirect;
    word_t     redirect_pc;

    // Fetch to decode
    word_t     fd_insn;
    word_t     fd_pc_next;

    // Register file ports
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;

    // Decode to execute
    word_t     dx_insn;
    word_t     dx_pc_next;
    word_t     dx_a;
    word_t     dx_b;

    // Execute to memory
    word_t     xm_insn;
    word_t     xm_result;
    word_t     xm_store;

    // Register write, also the writeback bypass
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;

    fetch_stage #(
        .reset_pc (reset_pc)
    ) i_fetch (
        .clock       (clock),
        .reset       (reset),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .q_imem      (q_imem),
        .pc          (address_imem),
        .fd_insn     (fd_insn),
        .fd_pc_next  (fd_pc_next)
    );

    decode_stage i_decode (
        .clock      (clock),
        .reset      (reset),
        .fd_insn    (fd_insn),
        .fd_pc_next (fd_pc_next),
        .redirect   (redirect),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .stall      (stall),
        .dx_insn    (dx_insn),
        .dx_pc_next (dx_pc_next),
        .dx_a       (dx_a),
        .dx_b       (dx_b)
    );

    register_file i_register_file (
        .clock   (clock),
        .reset   (reset),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .wb_addr (wb_addr),
        .wb_en   (wb_en),
        .wb_data (wb_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    execute_stage i_execute (
        .clock       (clock),
        .reset       (reset),
        .dx_insn     (dx_insn),
        .dx_pc_next  (dx_pc_next),
        .dx_a        (dx_a),
        .dx_b        (dx_b),
        .wb_en       (wb_en),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .xm_insn     (xm_insn),
        .xm_result   (xm_result),
        .xm_store    (xm_store)
    );

    // The writeback instruction word is not needed outside its own stage
    memory_writeback i_memory_writeback (
        .clock        (clock),
        .reset        (reset),
        .xm_insn      (xm_insn),
        .xm_result    (xm_result),
        .xm_store     (xm_store),
        .q_dmem       (q_dmem),
        .address_dmem (address_dmem),
        .data         (data),
        .wren         (wren),
        .wb_en        (wb_en),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .mw_insn      ()
    );

endmodule

// File: test/processor_properties.sv
`timescale 1ns/1ns
// Concurrent checks on the processor's pipeline control.
// Bound to processor from the testbench; sees the internal stall and
// redirect signals through the bind port list.
module processor_properties
    import cpu_pkg::*;
(
    input logic  clock,
    input logic  reset,
    input logic  wren,
    input logic  stall,
    input logic  redirect,
    input word_t redirect_pc,
    input word_t address_imem
);

    // From the second reset cycle on, the pipeline registers hold nops
    quiet_in_reset: assert property (
        @(posedge clock) (reset ##1 reset) |-> (!wren && !redirect)
    ) else $error("wren or redirect high during reset");

    // The bubble after a load-use stall clears the hazard
    single_stall: assert property (
        @(posedge clock) disable iff (reset) stall |=> !stall
    ) else $error("stall high in two consecutive cycles");

    redirect_target: assert property (
        @(posedge clock) disable iff (reset)
        redirect |=> (address_imem == $past(redirect_pc))
    ) else $error("fetch address differs from the redirect target");

endmodule

// File: test/program_rom.svh
// Test program and expected stores for the processor testbench.
// Included inside processor_tb after program_base is declared.
// build_program fills the instruction table and the expected-store table.
// Loads read the data memory fill value, 0xda7a0000 xor the word address.

word_t program_q [$];
word_t store_addr_q [$];
word_t store_data_q [$];

function automatic word_t alu_insn(alu_op_t fn, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt,
                                   logic [4:0] shamt);
    return {op_alu, rd, rs, rt, shamt, fn, 2'b00};
endfunction

// addi, lw, sw and the branches share this layout
function automatic word_t imm_insn(opcode_t op, reg_addr_t rd, reg_addr_t rs, int imm);
    logic [16:0] imm_bits;
    imm_bits = imm[16:0];
    return {op, rd, rs, imm_bits};
endfunction

function automatic word_t jump_insn(opcode_t op, word_t target);
    return {op, target[26:0]};
endfunction

task automatic append_insn(word_t insn);
    program_q.push_back(insn);
endtask

task automatic expect_store(word_t addr, word_t value);
    store_addr_q.push_back(addr);
    store_data_q.push_back(value);
endtask

task automatic build_program();
    // 0 to 12: dependent ALU chain, values forwarded from memory and writeback
    append_insn(imm_insn(op_addi, 1, 0, 5));
    append_insn(imm_insn(op_addi, 2, 1, 7));
    append_insn(alu_insn(alu_sub, 3, 2, 1, 0));
    append_insn(imm_insn(op_sw, 3, 0, 64));
    append_insn(imm_insn(op_addi, 4, 0, -3));
    append_insn(alu_insn(alu_sra, 5, 4, 0, 1));
    append_insn(alu_insn(alu_sll, 6, 1, 0, 4));
    append_insn(alu_insn(alu_or, 7, 6, 3, 0));
    append_insn(alu_insn(alu_add, 8, 7, 5, 0));
    append_insn(imm_insn(op_sw, 8, 0, 65));
    append_insn(alu_insn(alu_and, 9, 4, 2, 0));
    append_insn(imm_insn(op_sw, 9, 0, 66));
    append_insn(imm_insn(op_sw, 5, 0, 67));
    // 13 to 21: load-use stalls and a store of a just loaded register
    append_insn(imm_insn(op_lw, 10, 0, 20));
    append_insn(imm_insn(op_addi, 11, 10, 1));
    append_insn(imm_insn(op_sw, 11, 0, 68));
    append_insn(imm_insn(op_lw, 12, 0, 33));
    append_insn(imm_insn(op_sw, 12, 0, 69));
    append_insn(imm_insn(op_addi, 13, 0, 30));
    append_insn(imm_insn(op_lw, 14, 13, 2));
    append_insn(alu_insn(alu_add, 15, 14, 1, 0));
    append_insn(imm_insn(op_sw, 15, 0, 70));
    // 22 taken to 25, 25 falls through
    append_insn(imm_insn(op_bne, 2, 1, 2));
    append_insn(imm_insn(op_sw, 1, 0, 100));
    append_insn(imm_insn(op_sw, 1, 0, 101));
    append_insn(imm_insn(op_bne, 1, 1, 5));
    append_insn(imm_insn(op_sw, 2, 0, 71));
    // blt is taken when R[rd] < R[rs], so 27 goes to 29, then 29 and 30 fall through
    append_insn(imm_insn(op_blt, 4, 1, 1));
    append_insn(imm_insn(op_sw, 1, 0, 102));
    append_insn(imm_insn(op_blt, 1, 4, 3));
    append_insn(imm_insn(op_blt, 1, 1, 3));
    append_insn(imm_insn(op_sw, 4, 0, 72));
    // 33 compares a register forwarded from memory, taken to 35
    append_insn(imm_insn(op_addi, 16, 0, 9));
    append_insn(imm_insn(op_bne, 16, 0, 1));
    append_insn(imm_insn(op_sw, 1, 0, 103));
    // 35 jal to 38, 40 jr to 43, 43 j to 45
    append_insn(jump_insn(op_jal, program_base + 38));
    append_insn(imm_insn(op_sw, 1, 0, 104));
    append_insn(imm_insn(op_sw, 1, 0, 105));
    append_insn(imm_insn(op_sw, 31, 0, 73));
    append_insn(imm_insn(op_addi, 17, 0, program_base + 43));
    append_insn(imm_insn(op_jr, 17, 0, 0));
    append_insn(imm_insn(op_sw, 1, 0, 106));
    append_insn(imm_insn(op_sw, 1, 0, 107));
    append_insn(jump_insn(op_j, program_base + 45));
    append_insn(imm_insn(op_sw, 1, 0, 108));
    append_insn(imm_insn(op_sw, 17, 0, 74));
    // Parks on itself
    append_insn(jump_insn(op_j, program_base + 46));

    expect_store(32'd64, 32'h0000_0007);
    expect_store(32'd65, 32'h0000_0055);
    expect_store(32'd66, 32'h0000_000c);
    expect_store(32'd67, 32'hffff_fffe);
    expect_store(32'd68, 32'hda7a_0015);
    expect_store(32'd69, 32'hda7a_0021);
    expect_store(32'd70, 32'hda7a_0025);
    expect_store(32'd71, 32'h0000_000c);
    expect_store(32'd72, 32'hffff_fffd);
    // Link value is the jal address plus one
    expect_store(32'd73, program_base + 36);
    expect_store(32'd74, program_base + 43);
endtask

// File: test/processor_tb.sv
`timescale 1ns/1ns
// Testbench for the pipelined processor.
// Models both memories as arrays driven on the falling clock edge, runs the
// program from program_rom.svh and compares every store with the expected
// table in order. A cycle limit ends a run that stops making progress.
module processor_tb
    import cpu_pkg::*;
();

    localparam word_t program_base = 32'd8;
    localparam int reset_cycles = 8;
    localparam int drain_cycles = 8;
    localparam int mem_depth = 256;

    logic  clock;
    logic  reset;
    word_t address_imem;
    word_t q_imem;
    word_t address_dmem;
    word_t data;
    logic  wren;
    word_t q_dmem;

    word_t imem [mem_depth];
    word_t dmem [mem_depth];

    // Stores seen on the data memory port, in order
    word_t seen_addr_q [$];
    word_t seen_data_q [$];

    int cycle_count;
    int cycle_limit;
    int mismatch_count;
    int failure_count;

    `include "program_rom.svh"

    processor #(
        .reset_pc (program_base)
    ) i_dut (
        .clock        (clock),
        .reset        (reset),
        .address_imem (address_imem),
        .q_imem       (q_imem),
        .address_dmem (address_dmem),
        .data         (data),
        .wren         (wren),
        .q_dmem       (q_dmem)
    );

    bind processor processor_properties i_properties (
        .clock        (clock),
        .reset        (reset),
        .wren         (wren),
        .stall        (stall),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .address_imem (address_imem)
    );

    function automatic word_t data_fill_value(int index);
        return 32'hda7a_0000 ^ word_t'(index);
    endfunction

    task automatic load_memories();
        for (int i = 0; i < mem_depth; i++) begin
            imem[i] = nop;
            dmem[i] = data_fill_value(i);
        end
        for (int k = 0; k < program_q.size(); k++) begin
            imem[program_base + k] = program_q[k];
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Memory side of the DUT, addresses are stable in the middle of the cycle
    always @(negedge clock) begin
        assert (!(reset === 1'b1 && wren === 1'b1)) else begin
            failure_count++;
            $display("store issued while reset is asserted, cycle %0d", cycle_count);
        end
        if (reset !== 1'b1 && wren === 1'b1) begin
            seen_addr_q.push_back(address_dmem);
            seen_data_q.push_back(data);
            dmem[address_dmem[7:0]] = data;
        end
        q_imem = imem[address_imem[7:0]];
        q_dmem = dmem[address_dmem[7:0]];
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            failure_count++;
            $display("timeout after %0d cycles, %0d of %0d stores seen", cycle_count,
                     seen_addr_q.size(), store_addr_q.size());
            $display("errors: %0d mismatches, %0d other failures", mismatch_count,
                     failure_count);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        mismatch_count = 0;
        failure_count = 0;
        cycle_count = 0;
        reset = 1'b1;
        q_imem = nop;
        q_dmem = '0;
        build_program();
        load_memories();
        cycle_limit = program_q.size() * 4 + reset_cycles;

        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        assert (address_imem == program_base) else begin
            mismatch_count++;
            $display("mismatch address_imem after reset: got %h expected %h",
                     address_imem, program_base);
        end

        for (int row = 0; row < store_addr_q.size(); row++) begin
            while (seen_addr_q.size() <= row) begin
                @(posedge clock);
            end
            assert (seen_addr_q[row] == store_addr_q[row]) else begin
                mismatch_count++;
                $display("mismatch address_dmem in store %0d: got %h expected %h", row,
                         seen_addr_q[row], store_addr_q[row]);
            end
            assert (seen_data_q[row] == store_data_q[row]) else begin
                mismatch_count++;
                $display("mismatch data in store %0d: got %h expected %h", row,
                         seen_data_q[row], store_data_q[row]);
            end
        end

        // Skipped marker stores would show up here as extra stores
        repeat (drain_cycles) @(posedge clock);
        assert (seen_addr_q.size() == store_addr_q.size()) else begin
            failure_count++;
            $display("%0d stores seen where %0d were expected", seen_addr_q.size(),
                     store_addr_q.size());
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+test
source/cpu_pkg.sv
source/alu.sv
source/register_file.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_writeback.sv
source/processor.sv
test/processor_properties.sv
test/processor_tb.sv
